// ==== flist.f ====
logic/rv_isa_pkg.sv
logic/rv_mem_pkg.sv
logic/rv_fetch_ctrl.sv
logic/rv_fetch_buf.sv
logic/rv_fetch_top.sv
tests/tb_imem_model.sv
tests/tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_fetch_top -f flist.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_fetch_top > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top;

    localparam int CLK_HALF = 10;
    localparam int RESET_CYCLES = 3;
    localparam int MEM_AW = 6;
    localparam int HALF_N = 2 ** (MEM_AW + 1);
    localparam int IMAGE_BYTES = 2 * HALF_N;
    localparam int SEQ_INSTRS = 12;
    localparam int REDIR_INSTRS = 6;
    // generous, random decode stalls included.
    localparam int CYCLES_PER_HALF = 8;
    localparam int BUDGET = RESET_CYCLES + 200 + HALF_N * CYCLES_PER_HALF
                            + (SEQ_INSTRS + 2 * REDIR_INSTRS) * 2 * CYCLES_PER_HALF;

    logic                           clk;
    logic                           reset_n;
    logic                           redirect;
    logic [rv_isa_pkg::XLEN-1:0]    redirect_pc;
    logic                           decode_ready;
    logic                           imem_ack;
    logic [rv_mem_pkg::DATA_W-1:0]  imem_data;
    logic                           imem_req;
    logic [rv_mem_pkg::ADDR_W-1:0]  imem_addr;
    logic [rv_isa_pkg::XLEN-1:0]    instr;
    logic                           instr_valid;
    logic [rv_isa_pkg::XLEN-1:0]    pc;
    logic [rv_isa_pkg::XLEN-1:0]    exp_pc;
    logic [MEM_AW:0]                exp_idx;
    logic [MEM_AW:0]                exp_idx_hi;
    logic [rv_isa_pkg::HALF_W-1:0]  exp_lo;
    logic [rv_isa_pkg::HALF_W-1:0]  exp_hi;
    logic                           exp_full;
    logic                           back_pressure;
    int                             valid_count;
    int                             err_count;
    int                             seed;

    rv_fetch_top #(
        .BUF_ADDR_W     (2)
    ) u_dut
    (
        .i_clk          (clk),
        .i_reset_n      (reset_n),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc),
        .i_imem_ack     (imem_ack),
        .i_imem_data    (imem_data),
        .i_decode_ready (decode_ready),
        .o_imem_req     (imem_req),
        .o_imem_addr    (imem_addr),
        .o_instr        (instr),
        .o_instr_valid  (instr_valid),
        .o_pc           (pc)
    );

    tb_imem_model #(
        .MEM_AW     (MEM_AW)
    ) u_mem
    (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .i_req      (imem_req),
        .i_addr     (imem_addr),
        .o_ack      (imem_ack),
        .o_data     (imem_data)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // reference instruction at the expected pc, read straight from the image.
    assign exp_idx = exp_pc[MEM_AW+1:1];
    assign exp_idx_hi = exp_idx + 1'b1;
    assign exp_lo = u_mem.half[exp_idx];
    assign exp_hi = u_mem.half[exp_idx_hi];
    assign exp_full = (exp_lo[1:0] == rv_isa_pkg::OPC_FULL);

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            exp_pc <= rv_isa_pkg::RESET_PC;
            valid_count <= 0;
        end
        else if (redirect)
            exp_pc <= redirect_pc;
        else if (instr_valid)
        begin
            exp_pc <= exp_pc + (exp_full ? 32'd4 : 32'd2);
            valid_count <= valid_count + 1;
        end
    end

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        err_count++;
        $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    a_pc: assert property (@(posedge clk) disable iff (!reset_n)
        instr_valid |-> (pc == exp_pc))
        else flag_mismatch("o_pc", $sampled(pc), $sampled(exp_pc));

    a_lo: assert property (@(posedge clk) disable iff (!reset_n)
        instr_valid |-> (instr[15:0] == exp_lo))
        else flag_mismatch("o_instr low half", {16'h0, $sampled(instr[15:0])},
                           {16'h0, $sampled(exp_lo)});

    a_hi: assert property (@(posedge clk) disable iff (!reset_n)
        (instr_valid && exp_full) |-> (instr[31:16] == exp_hi))
        else flag_mismatch("o_instr high half", {16'h0, $sampled(instr[31:16])},
                           {16'h0, $sampled(exp_hi)});

    a_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !instr_valid |-> (instr == '0))
        else flag_mismatch("idle o_instr", $sampled(instr), 32'h0);

    // memory requests are word aligned.
    a_align: assert property (@(posedge clk) disable iff (!reset_n)
        imem_req |-> (imem_addr[1:0] == 2'b00))
        else flag_mismatch("o_imem_addr low bits", {30'h0, $sampled(imem_addr[1:0])}, 32'h0);

    // at most one request in flight.
    a_single: assert property (@(posedge clk) disable iff (!reset_n)
        imem_req |=> !imem_req)
        else flag_mismatch("o_imem_req after a request", 32'h1, 32'h0);

    // one clock, with a fresh decode ready draw.
    task automatic step();
        @(posedge clk);
        if (back_pressure)
            decode_ready <= ($random(seed) >= 0);
        else
            decode_ready <= 1'b1;
    endtask

    task automatic wait_instrs(input int n);
        int target;
        target = valid_count + n;
        while (valid_count < target)
            step();
    endtask

    // skew 0 lands in the acknowledge cycle, skew 1 on the next request.
    task automatic redirect_to(input logic [31:0] target, input int skew);
        step();
        while (!imem_req)
            step();
        repeat (skew) step();
        redirect <= 1'b1;
        redirect_pc <= target;
        step();
        redirect <= 1'b0;
    endtask

    // first instruction boundary in the upper half of a word at or after from.
    function automatic logic [31:0] odd_boundary_after(input logic [31:0] from);
        logic [31:0] a;
        a = rv_isa_pkg::RESET_PC;
        while ((a < from) || !a[1])
            a = a + ((u_mem.half[a[MEM_AW+1:1]][1:0] == rv_isa_pkg::OPC_FULL) ? 32'd4 : 32'd2);
        return a;
    endfunction

    initial
    begin
        seed = 32'h3bd2edee;
        err_count = 0;
        back_pressure = 1'b0;
        reset_n = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        decode_ready = 1'b1;
        repeat (RESET_CYCLES) step();
        reset_n <= 1'b1;
        step();
        a_reset: assert (!imem_req && !instr_valid && (pc == rv_isa_pkg::RESET_PC))
            else
            begin
                err_count++;
                $display("ERROR at %0t: fetch front end is not idle at RESET_PC after reset",
                         $time);
            end

        // full, compressed and straddling instructions with decode always ready.
        wait_instrs(SEQ_INSTRS);

        redirect_to(odd_boundary_after(32'd20), 0);
        wait_instrs(REDIR_INSTRS);
        redirect_to(odd_boundary_after(32'd100), 1);
        wait_instrs(REDIR_INSTRS);

        // whole image under random decode stalls.
        back_pressure = 1'b1;
        redirect_to(rv_isa_pkg::RESET_PC, 0);
        while (exp_pc < IMAGE_BYTES)
            step();

        $display("run complete with %0d errors", err_count);
        if (err_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        #(2 * CLK_HALF * BUDGET);
        $display("timeout, the run did not finish within %0d cycles", BUDGET);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_imem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_imem_model
#(
    parameter int MEM_AW = 6
)
(
    input  wire                             i_clk,
    input  wire                             i_reset_n,
    input  wire                             i_req,
    input  wire [rv_mem_pkg::ADDR_W-1:0]    i_addr,
    output logic                            o_ack,
    output logic [rv_mem_pkg::DATA_W-1:0]   o_data
);

    localparam int HALF_N = 2 ** (MEM_AW + 1);

    // instruction lengths in program order, a set bit is a 32-bit instruction.
    localparam logic [15:0] FULL_MAP = 16'b1000_1101_0010_1111;

    logic [rv_isa_pkg::HALF_W-1:0]  half [0:HALF_N-1];
    logic [MEM_AW-1:0]              word_idx;

    initial
    begin
        int h;
        int k;
        h = 0;
        k = 0;
        while (h < HALF_N)
        begin
            // a 32-bit instruction never runs past the end of the image.
            if (FULL_MAP[k % 16] && (h + 1 < HALF_N))
            begin
                half[h] = {h[13:0], rv_isa_pkg::OPC_FULL};
                half[h + 1] = ~h[15:0];
                h = h + 2;
            end
            else
            begin
                half[h] = {h[13:0], (k[0] ? 2'b01 : 2'b10)};
                h = h + 1;
            end
            k = k + 1;
        end
    end

    assign word_idx = i_addr[rv_mem_pkg::WORD_OFF +: MEM_AW];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_ack <= 1'b0;
            o_data <= '0;
        end
        else
        begin
            o_ack <= i_req;
            o_data <= {half[{word_idx, 1'b1}], half[{word_idx, 1'b0}]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_fetch_top
#(
    parameter int BUF_ADDR_W = 2
)
(
    input  wire                             i_clk,
    input  wire                             i_reset_n,
    input  wire                             i_redirect,
    input  wire [rv_isa_pkg::XLEN-1:0]      i_redirect_pc,
    input  wire                             i_imem_ack,
    input  wire [rv_mem_pkg::DATA_W-1:0]    i_imem_data,
    input  wire                             i_decode_ready,
    output logic                            o_imem_req,
    output logic [rv_mem_pkg::ADDR_W-1:0]   o_imem_addr,
    output logic [rv_isa_pkg::XLEN-1:0]     o_instr,
    output logic                            o_instr_valid,
    output logic [rv_isa_pkg::XLEN-1:0]     o_pc
);

    logic [rv_isa_pkg::XLEN-1:0]    fetch_pc_next;
    logic                           pc_select;
    logic                           fetch_pc1;
    logic                           ack;
    logic                           free_dword_or_more;
    logic [2:0]                     pc_incr;

    rv_fetch_ctrl u_ctrl
    (
        .i_clk                  (i_clk),
        .i_reset_n              (i_reset_n),
        .i_redirect             (i_redirect),
        .i_redirect_pc          (i_redirect_pc),
        .i_imem_ack             (i_imem_ack),
        .i_free_dword_or_more   (free_dword_or_more),
        .i_pc_incr              (pc_incr),
        .o_imem_req             (o_imem_req),
        .o_imem_addr            (o_imem_addr),
        .o_fetch_pc_next        (fetch_pc_next),
        .o_pc_select            (pc_select),
        .o_fetch_pc1            (fetch_pc1),
        .o_ack                  (ack)
    );

    // decode only looks at the valid strobe, so ready stays inside.
    rv_fetch_buf #(
        .BUF_ADDR_W             (BUF_ADDR_W)
    ) u_buf
    (
        .i_clk                  (i_clk),
        .i_reset_n              (i_reset_n),
        .i_pc_select            (pc_select),
        .i_ack                  (ack),
        .i_decode_ready         (i_decode_ready),
        .i_data                 (i_imem_data),
        .i_fetch_pc1            (fetch_pc1),
        .i_fetch_pc_next        (fetch_pc_next),
        .o_free_dword_or_more   (free_dword_or_more),
        .o_pc_incr              (pc_incr),
        .o_pc                   (o_pc),
        .o_instr                (o_instr),
        .o_instr_valid          (o_instr_valid),
        .o_instr_ready          ()
    );

endmodule

`default_nettype wire

// ==== logic/rv_fetch_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_fetch_buf
#(
    parameter int BUF_ADDR_W = 2
)
(
    input  wire                             i_clk,
    input  wire                             i_reset_n,
    input  wire                             i_pc_select,
    input  wire                             i_ack,
    input  wire                             i_decode_ready,
    input  wire [rv_mem_pkg::DATA_W-1:0]    i_data,
    input  wire                             i_fetch_pc1,
    input  wire [rv_isa_pkg::XLEN-1:0]      i_fetch_pc_next,
    output logic                            o_free_dword_or_more,
    output logic [2:0]                      o_pc_incr,
    output logic [rv_isa_pkg::XLEN-1:0]     o_pc,
    output logic [rv_isa_pkg::XLEN-1:0]     o_instr,
    output logic                            o_instr_valid,
    output logic                            o_instr_ready
);

    localparam int DEPTH_N = 2 ** BUF_ADDR_W;
    localparam int CNT_W = BUF_ADDR_W + 1;
    localparam int Q_W = DEPTH_N * rv_isa_pkg::HALF_W;
    localparam int HW = rv_isa_pkg::HALF_W;
    localparam logic [CNT_W-1:0] DEPTH = CNT_W'(DEPTH_N);

    // halfword queue, entry 0 in the low bits is the head.
    logic [Q_W-1:0]                 queue_q;
    logic [Q_W-1:0]                 queue_shift;
    logic [Q_W-1:0]                 queue_next;
    logic [CNT_W-1:0]               free_cnt;
    logic [CNT_W-1:0]               free_after_pop;
    logic [CNT_W-1:0]               free_cnt_next;
    logic [CNT_W-1:0]               pop_amt;
    logic [CNT_W-1:0]               push_amt;
    logic [CNT_W-1:0]               wr_idx;
    logic [rv_isa_pkg::XLEN-1:0]    pc;
    logic [rv_isa_pkg::XLEN-1:0]    pc_next;
    logic                           fetch_pc1_q;
    logic                           decode_ready_q;
    logic                           move;
    logic                           head_comp;
    logic                           pop_word;
    logic                           pop_dword;
    logic                           push_word;
    logic                           push_dword;

    // a whole instruction sits at the head of a queue holding used entries.
    function automatic logic instr_held(input logic [1:0] opc, input logic [CNT_W-1:0] used);
        instr_held = (used != '0) && ((opc != rv_isa_pkg::OPC_FULL) || (used > CNT_W'(1)));
    endfunction

    assign head_comp = (queue_q[1:0] != rv_isa_pkg::OPC_FULL);

    assign push_dword = i_ack & !fetch_pc1_q;
    assign push_word = i_ack & fetch_pc1_q;
    assign pop_dword = move & !head_comp;
    assign pop_word = move & head_comp;

    assign pop_amt = pop_dword ? CNT_W'(2) : (pop_word ? CNT_W'(1) : '0);
    assign push_amt = push_dword ? CNT_W'(2) : (push_word ? CNT_W'(1) : '0);

    // pops go first, so a push lands right behind what is left.
    assign free_after_pop = free_cnt + pop_amt;
    assign wr_idx = DEPTH - free_after_pop;
    assign free_cnt_next = i_pc_select ? DEPTH : (free_after_pop - push_amt);

    assign queue_shift = pop_dword ? (queue_q >> (2 * HW)) :
                         pop_word  ? (queue_q >> HW) :
                                     queue_q;

    always_comb
    begin
        queue_next = queue_shift;
        for (int i = 0; i < DEPTH_N; i++)
        begin
            if (push_word && (CNT_W'(i) == wr_idx))
                queue_next[i*HW +: HW] = i_data[rv_mem_pkg::DATA_W-1:HW];
            if (push_dword && (CNT_W'(i) == wr_idx))
                queue_next[i*HW +: HW] = i_data[HW-1:0];
            if (push_dword && (CNT_W'(i) == wr_idx + CNT_W'(1)))
                queue_next[i*HW +: HW] = i_data[rv_mem_pkg::DATA_W-1:HW];
        end
    end

    assign pc_next = i_pc_select ? i_fetch_pc_next :
                     pop_dword   ? pc + rv_isa_pkg::XLEN'(4) :
                     pop_word    ? pc + rv_isa_pkg::XLEN'(2) :
                                   pc;

    always_ff @(posedge i_clk)
    begin
        queue_q <= queue_next;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            free_cnt <= DEPTH;
            pc <= i_fetch_pc_next;
            fetch_pc1_q <= 1'b0;
            decode_ready_q <= 1'b0;
            move <= 1'b0;
        end
        else
        begin
            free_cnt <= free_cnt_next;
            pc <= pc_next;
            fetch_pc1_q <= i_fetch_pc1;
            decode_ready_q <= i_decode_ready;
            // judged on the state after this edge, so a popped head is not sent twice.
            move <= decode_ready_q & instr_held(queue_next[1:0], DEPTH - free_cnt_next);
        end
    end

    // a half word fetch moves the fetch address onto the next word boundary.
    assign o_pc_incr = fetch_pc1_q ? 3'd2 : 3'd4;
    assign o_free_dword_or_more = (free_cnt_next > CNT_W'(1));

    assign o_instr_ready = instr_held(queue_q[1:0], DEPTH - free_cnt);
    assign o_instr_valid = move & !i_pc_select;
    assign o_instr = o_instr_valid ? queue_q[2*HW-1:0] : '0;
    assign o_pc = pc;

endmodule

`default_nettype wire

// ==== logic/rv_fetch_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_fetch_ctrl
(
    input  wire                             i_clk,
    input  wire                             i_reset_n,
    input  wire                             i_redirect,
    input  wire [rv_isa_pkg::XLEN-1:0]      i_redirect_pc,
    input  wire                             i_imem_ack,
    input  wire                             i_free_dword_or_more,
    input  wire [2:0]                       i_pc_incr,
    output logic                            o_imem_req,
    output logic [rv_mem_pkg::ADDR_W-1:0]   o_imem_addr,
    output logic [rv_isa_pkg::XLEN-1:0]     o_fetch_pc_next,
    output logic                            o_pc_select,
    output logic                            o_fetch_pc1,
    output logic                            o_ack
);

    logic [rv_isa_pkg::XLEN-1:0]    fetch_pc;
    logic                           in_flight;
    logic                           stale;

    // request is on the bus this cycle, its acknowledge comes next cycle.
    assign o_imem_req = in_flight;

    assign o_imem_addr = {fetch_pc[rv_mem_pkg::ADDR_W-1:rv_mem_pkg::WORD_OFF],
                          {rv_mem_pkg::WORD_OFF{1'b0}}};

    // halfword-aligned target, only the upper half of the word is wanted.
    assign o_fetch_pc1 = fetch_pc[1];

    assign o_pc_select = i_redirect;
    assign o_fetch_pc_next = i_redirect ? i_redirect_pc : rv_isa_pkg::RESET_PC;

    // an acknowledge for the old stream never reaches the buffer.
    assign o_ack = i_imem_ack & !stale & !i_redirect;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            fetch_pc <= rv_isa_pkg::RESET_PC;
            in_flight <= 1'b0;
            stale <= 1'b0;
        end
        else
        begin
            if (i_redirect)
                fetch_pc <= i_redirect_pc;
            else if (o_ack)
                fetch_pc <= fetch_pc + rv_isa_pkg::XLEN'(i_pc_incr);

            // one request at a time, and only with room for a whole word.
            in_flight <= !in_flight & i_free_dword_or_more;

            // the request now on the bus belongs to the old stream.
            stale <= i_redirect & in_flight;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_mem_pkg.sv ====
`default_nettype none

package rv_mem_pkg;

    // instruction memory byte address.
    localparam int ADDR_W = 32;

    // one memory word per request.
    localparam int DATA_W = 32;

    // address bits below the word boundary.
    localparam int WORD_OFF = 2;

endpackage

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // program counter and full instruction width.
    localparam int XLEN = 32;

    // one buffer entry, the size of a compressed instruction.
    localparam int HALF_W = 16;

    // low opcode bits of a 32-bit instruction.
    // anything else is compressed.
    localparam logic [1:0] OPC_FULL = 2'b11;

    // first fetch address out of reset.
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
